// ==== common/socBusPkg.sv ====
// shared bus structs and enums for socBus, referenced by scoped name from every block

`default_nettype none

package socBusPkg;

    // master side transfer
    // read and write never high together
    typedef struct packed {
        logic [31:0] address;
        logic        read;
        logic        write;
        logic [31:0] writeData;
    } busRequest;

    // read return from a slave or the interconnect
    typedef struct packed {
        logic [31:0] data;
        logic        valid;
    } busResponse;

    // per-slave request after decode
    // wordAddress is relative to the slave window
    typedef struct packed {
        logic       read;
        logic       write;
        logic [7:0] wordAddress;
        logic [31:0] writeData;
    } slaveRequest;

    // decode result
    typedef enum logic [1:0] {
        selRam,
        selRandom,
        selTimer,
        selNone
    } slaveSel;

    // timer register word offsets
    typedef enum logic [1:0] {
        regCount   = 2'd0,
        regCompare = 2'd1,
        regControl = 2'd2,
        regStatus  = 2'd3
    } timerReg;

endpackage

`default_nettype wire

// ==== common/socBus_settings.svh ====
// address map and sizing macros for socBus, included by the blocks that decode or size memory

`ifndef SOCBUS_SETTINGS_SVH
`define SOCBUS_SETTINGS_SVH

// byte base of each device window
`define RAM_BASE       32'h00000000
`define RANDOM_BASE    32'h00005000
`define TIMER_BASE     32'h00005100

// window sizes in bytes
// every register is one 32-bit word
`define RAM_SIZE       32'h400
`define RANDOM_SIZE    32'h4
`define TIMER_SIZE     32'h10

// ram depth in words
`define RAM_WORDS      (`RAM_SIZE / 4)

// galois feedback mask for the random source
// x^32 + x^22 + x^2 + x + 1, right-shifting form
`define RANDOM_TAPS    32'h80200003

// shifts after each read
// random source stalls the bus for this many cycles
`define RANDOM_STEPS   8

// lfsr state out of reset
// must not be zero, an all-zero galois lfsr never leaves zero
`define RANDOM_SEED    32'hACE15EED

`endif

// ==== design/randomSource.sv ====
// random number slave for socBus, a Galois LFSR that restirs for a few cycles after each read

`default_nettype none

`include "socBus_settings.svh"

module randomSource (
    input  logic                   clk,
    input  logic                   reset,
    input  socBusPkg::slaveRequest req,
    output socBusPkg::busResponse  resp,
    output logic                   busy
);

    localparam int stepBits = $clog2(`RANDOM_STEPS + 1);

    logic [31:0]         state;
    logic [stepBits-1:0] stepsLeft;
    logic [31:0]         readData;
    logic                readValid;

    // lfsr and restir counter
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= `RANDOM_SEED;
            stepsLeft <= '0;
            readValid <= 1'b0;
        end else begin
            readValid <= req.read;
            if (stepsLeft != '0) begin
                // galois step, right shift with feedback on bit 0
                state     <= (state >> 1) ^ (state[0] ? `RANDOM_TAPS : 32'h0);
                stepsLeft <= stepsLeft - 1'b1;
            end else if (req.read) begin
                stepsLeft <= stepBits'(`RANDOM_STEPS);
            end else if (req.write && (req.writeData != 32'h0)) begin
                // zero seed would lock up, so it is dropped
                state <= req.writeData;
            end
        end
    end

    // captured value for the pending read
    always_ff @(posedge clk) begin
        if (req.read) begin
            readData <= state;
        end
    end

    assign busy       = (stepsLeft != '0);
    assign resp.data  = readData;
    assign resp.valid = readValid;

endmodule

`default_nettype wire

// ==== design/scratchRam.sv ====
// word-addressed scratch RAM slave for socBus with a one-cycle registered read

`default_nettype none

`include "socBus_settings.svh"

module scratchRam (
    input  logic                   clk,
    input  logic                   reset,
    input  socBusPkg::slaveRequest req,
    output socBusPkg::busResponse  resp
);

    logic [31:0] mem [`RAM_WORDS];
    logic [31:0] readData;
    logic        readValid;

    // storage and read data path
    always_ff @(posedge clk) begin
        if (req.write) begin
            mem[req.wordAddress] <= req.writeData;
        end
        // read word lands next cycle
        if (req.read) begin
            readData <= mem[req.wordAddress];
        end
    end

    // valid flag, one cycle after the read strobe
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            readValid <= 1'b0;
        end else begin
            readValid <= req.read;
        end
    end

    assign resp.data  = readData;
    assign resp.valid = readValid;

endmodule

`default_nettype wire

// ==== design/socPeripheralTop.sv ====
// top level of the socBus peripheral subsystem, wires the interconnect to RAM, random source and timer

`default_nettype none

module socPeripheralTop (
    input  logic                  clk,
    input  logic                  reset,
    input  socBusPkg::busRequest  hostReq,
    output logic                  waitRequest,
    output socBusPkg::busResponse hostResp,
    output logic                  timerIrq
);

    // decoded requests
    socBusPkg::slaveRequest ramReq;
    socBusPkg::slaveRequest randomReq;
    socBusPkg::slaveRequest timerReq;

    // slave returns
    socBusPkg::busResponse  ramResp;
    socBusPkg::busResponse  randomResp;
    socBusPkg::busResponse  timerResp;
    logic                   randomBusy;

    socInterconnect interconnect0 (
        .clk         (clk),
        .reset       (reset),
        .hostReq     (hostReq),
        .waitRequest (waitRequest),
        .hostResp    (hostResp),
        .ramReq      (ramReq),
        .randomReq   (randomReq),
        .timerReq    (timerReq),
        .ramResp     (ramResp),
        .randomResp  (randomResp),
        .timerResp   (timerResp),
        .randomBusy  (randomBusy)
    );

    scratchRam ram0 (
        .clk   (clk),
        .reset (reset),
        .req   (ramReq),
        .resp  (ramResp)
    );

    randomSource random0 (
        .clk   (clk),
        .reset (reset),
        .req   (randomReq),
        .resp  (randomResp),
        .busy  (randomBusy)
    );

    tickTimer timer0 (
        .clk   (clk),
        .reset (reset),
        .req   (timerReq),
        .resp  (timerResp),
        .irq   (timerIrq)
    );

endmodule

`default_nettype wire

// ==== design/tickTimer.sv ====
// compare-match timer slave for socBus with four registers and a sticky match interrupt

`default_nettype none

module tickTimer (
    input  logic                   clk,
    input  logic                   reset,
    input  socBusPkg::slaveRequest req,
    output socBusPkg::busResponse  resp,
    output logic                   irq
);

    socBusPkg::timerReg regSel;
    logic [31:0]        count;
    logic [31:0]        compare;
    logic               enable;
    logic               autoReload;
    logic               matchFlag;
    logic               match;
    logic [31:0]        regValue;
    logic [31:0]        readData;
    logic               readValid;

    // register select from the low word address bits
    assign regSel = socBusPkg::timerReg'(req.wordAddress[1:0]);

    // match only counts while running
    assign match = enable && (count == compare);

    // counter, control and flag
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count      <= 32'h0;
            compare    <= 32'h0;
            enable     <= 1'b0;
            autoReload <= 1'b0;
            matchFlag  <= 1'b0;
        end else begin
            // free run
            if (match && autoReload) begin
                count <= 32'h0;
            end else if (enable) begin
                count <= count + 32'h1;
            end

            // bus writes override the count update
            if (req.write) begin
                case (regSel)
                    socBusPkg::regCount: begin
                        count <= req.writeData;
                    end
                    socBusPkg::regCompare: begin
                        compare <= req.writeData;
                    end
                    socBusPkg::regControl: begin
                        enable     <= req.writeData[0];
                        autoReload <= req.writeData[1];
                    end
                    socBusPkg::regStatus: begin
                        // write one to clear
                        if (req.writeData[0]) begin
                            matchFlag <= 1'b0;
                        end
                    end
                    default: begin
                    end
                endcase
            end

            // a new match beats a clear in the same cycle
            if (match) begin
                matchFlag <= 1'b1;
            end
        end
    end

    // read mux
    always_comb begin
        case (regSel)
            socBusPkg::regCount:   regValue = count;
            socBusPkg::regCompare: regValue = compare;
            socBusPkg::regControl: regValue = {30'h0, autoReload, enable};
            default:               regValue = {31'h0, matchFlag};
        endcase
    end

    // read data, registered
    always_ff @(posedge clk) begin
        if (req.read) begin
            readData <= regValue;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            readValid <= 1'b0;
        end else begin
            readValid <= req.read;
        end
    end

    assign resp.data  = readData;
    assign resp.valid = readValid;
    assign irq        = matchFlag;

endmodule

`default_nettype wire

// ==== interconnect/socInterconnect.sv ====
// address decoder and read data return for socBus, sits between the master and the three slaves

`default_nettype none

`include "socBus_settings.svh"

module socInterconnect (
    input  logic                   clk,
    input  logic                   reset,
    input  socBusPkg::busRequest   hostReq,
    output logic                   waitRequest,
    output socBusPkg::busResponse  hostResp,
    output socBusPkg::slaveRequest ramReq,
    output socBusPkg::slaveRequest randomReq,
    output socBusPkg::slaveRequest timerReq,
    input  socBusPkg::busResponse  ramResp,
    input  socBusPkg::busResponse  randomResp,
    input  socBusPkg::busResponse  timerResp,
    input  logic                   randomBusy
);

    socBusPkg::slaveSel sel;
    logic [31:0]        windowBase;
    logic [31:0]        offset;
    logic [7:0]         wordAddress;
    logic               readGo;
    logic               writeGo;
    logic               noneValid;
    logic [3:0]         validBus;

    // request for one slave, strobes only when it is the decoded target
    function automatic socBusPkg::slaveRequest makeRequest(input socBusPkg::slaveSel target);
        socBusPkg::slaveRequest r;
        r.read        = readGo && (sel == target);
        r.write       = writeGo && (sel == target);
        r.wordAddress = wordAddress;
        r.writeData   = hostReq.writeData;
        return r;
    endfunction

    // address map
    always_comb begin
        sel        = socBusPkg::selNone;
        windowBase = 32'h0;
        if ((hostReq.address >= `RAM_BASE) &&
            (hostReq.address <= (`RAM_BASE + (`RAM_SIZE - 1)))) begin
            sel        = socBusPkg::selRam;
            windowBase = `RAM_BASE;
        end
        if ((hostReq.address >= `RANDOM_BASE) &&
            (hostReq.address <= (`RANDOM_BASE + (`RANDOM_SIZE - 1)))) begin
            sel        = socBusPkg::selRandom;
            windowBase = `RANDOM_BASE;
        end
        if ((hostReq.address >= `TIMER_BASE) &&
            (hostReq.address <= (`TIMER_BASE + (`TIMER_SIZE - 1)))) begin
            sel        = socBusPkg::selTimer;
            windowBase = `TIMER_BASE;
        end
    end

    // word offset inside the selected window
    // the ram window is the widest at 256 words, so 8 bits covers all
    assign offset      = hostReq.address - windowBase;
    assign wordAddress = offset[9:2];

    // only the random source can stall
    assign waitRequest = (sel == socBusPkg::selRandom) && randomBusy;

    // accepted transfer this edge
    assign readGo  = hostReq.read && !waitRequest;
    assign writeGo = hostReq.write && !waitRequest;

    assign ramReq    = makeRequest(socBusPkg::selRam);
    assign randomReq = makeRequest(socBusPkg::selRandom);
    assign timerReq  = makeRequest(socBusPkg::selTimer);

    // unmapped read responder
    // answers one cycle later, same as any slave
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            noneValid <= 1'b0;
        end else begin
            noneValid <= readGo && (sel == socBusPkg::selNone);
        end
    end

    // return data selector
    always_comb begin
        validBus = {ramResp.valid, randomResp.valid, timerResp.valid, noneValid};
        case (validBus)
            4'b1000: hostResp.data = ramResp.data;
            4'b0100: hostResp.data = randomResp.data;
            4'b0010: hostResp.data = timerResp.data;
            // unmapped, or a collision, reads as zero
            default: hostResp.data = 32'h0;
        endcase
        hostResp.valid = |validBus;
    end

endmodule

`default_nettype wire

// ==== socBus.f ====
+incdir+common
common/socBusPkg.sv
interconnect/socInterconnect.sv
design/scratchRam.sv
design/randomSource.sv
design/tickTimer.sv
design/socPeripheralTop.sv
tb/socBus_assert.sv
tb/socBusTb.sv

// ==== tb/socBusTb.sv ====
// testbench for socBus, LFSR driven bus traffic checked against a model of RAM, random source and timer

`default_nettype none

`include "socBus_settings.svh"

module socBusTb;

    // budget per test, run stops at twice the sum
    localparam int cycleLimit = 2 * (64 * 6 + 16 * 8 + 12 * (`RANDOM_STEPS + 3) + 110 + 220 + 40);

    logic                  clk;
    logic                  reset;
    socBusPkg::busRequest  hostReq;
    logic                  waitRequest;
    socBusPkg::busResponse hostResp;
    logic                  timerIrq;

    // reference model
    logic [31:0] ramModel [`RAM_WORDS];
    logic [7:0]  ramUsed [$];
    logic [31:0] randomModel;

    logic [31:0] stimLfsr;
    int          cycleCount;
    int          errors;
    int          checks;
    int          testsFailed;
    int          testErrors;
    int          stalls;

    // pending read, checked at the next falling edge
    logic        expValid;
    logic        expExact;
    logic [31:0] expData;

    socPeripheralTop dut0 (
        .clk         (clk),
        .reset       (reset),
        .hostReq     (hostReq),
        .waitRequest (waitRequest),
        .hostResp    (hostResp),
        .timerIrq    (timerIrq)
    );

    always #50 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("run stopped after %0d cycles, a transfer never completed", cycleCount);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // stimulus lfsr, one shift per bit handed out
    function automatic logic [31:0] nextBits(input int n);
        logic [31:0] value;
        value = 32'h0;
        for (int i = 0; i < n; i++) begin
            stimLfsr = (stimLfsr >> 1) ^ (stimLfsr[0] ? 32'hB4BCD35C : 32'h0);
            value    = {value[30:0], stimLfsr[0]};
        end
        return value;
    endfunction

    // random source state after the restir that follows a read
    function automatic logic [31:0] stirred(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        for (int i = 0; i < `RANDOM_STEPS; i++) begin
            v = (v >> 1) ^ (v[0] ? `RANDOM_TAPS : 32'h0);
        end
        return v;
    endfunction

    function automatic logic [31:0] timerAddr(input socBusPkg::timerReg r);
        return `TIMER_BASE + {28'h0, r, 2'b00};
    endfunction

    task automatic failValue(input string name, input logic [31:0] got, input logic [31:0] want);
        errors++;
        $display("FAIL %s got 0x%08h expected 0x%08h", name, got, want);
    endtask

    // falling edge look at the return bus
    task automatic sample();
        @(negedge clk);
        if (expValid && (hostResp.valid !== 1'b1)) begin
            errors++;
            $display("no readValid on the cycle after an accepted read");
        end else if (!expValid && (hostResp.valid !== 1'b0)) begin
            errors++;
            $display("readValid raised without an accepted read");
        end else if (expValid && expExact) begin
            checks++;
            if (hostResp.data !== expData) begin
                failValue("hostResp.data", hostResp.data, expData);
            end
        end else if (expValid) begin
            // upper bound only, auto-reload count
            checks++;
            if (hostResp.data > expData) begin
                errors++;
                $display("FAIL hostResp.data got 0x%08h above limit 0x%08h",
                         hostResp.data, expData);
            end
        end
        expValid = 1'b0;
    endtask

    // one transfer held until accepted, then a read arms its expectation
    task automatic access(input logic [31:0] address, input logic write,
                          input logic [31:0] value, input logic exact);
        socBusPkg::busRequest req;
        logic                 accepted;
        req.address   = address;
        req.read      = !write;
        req.write     = write;
        req.writeData = write ? value : 32'h0;
        hostReq  <= req;
        stalls   = 0;
        accepted = 1'b0;
        while (!accepted) begin
            sample();
            accepted = (waitRequest === 1'b0);
            if (!accepted) begin
                stalls++;
            end
            @(posedge clk);
        end
        expValid = !write;
        expExact = exact;
        expData  = value;
    endtask

    task automatic idle(input int n);
        hostReq <= '0;
        repeat (n) begin
            sample();
            @(posedge clk);
        end
    endtask

    // idle cycle plus interrupt line check
    task automatic idleIrq(input logic want);
        hostReq <= '0;
        sample();
        checks++;
        if (timerIrq !== want) begin
            failValue("timerIrq", {31'h0, timerIrq}, {31'h0, want});
        end
        @(posedge clk);
    endtask

    task automatic checkStalls(input int want);
        checks++;
        if (stalls != want) begin
            failValue("waitRequest cycles", stalls, want);
        end
    endtask

    // stop, zero and rearm the timer, then start it
    task automatic timerStart(input logic [31:0] compare, input logic [31:0] control);
        access(timerAddr(socBusPkg::regControl), 1'b1, 32'h0, 1'b1);
        access(timerAddr(socBusPkg::regCount), 1'b1, 32'h0, 1'b1);
        access(timerAddr(socBusPkg::regCompare), 1'b1, compare, 1'b1);
        access(timerAddr(socBusPkg::regStatus), 1'b1, 32'h1, 1'b1);
        access(timerAddr(socBusPkg::regControl), 1'b1, control, 1'b1);
    endtask

    task automatic endTest(input int number, input string name);
        if (errors == testErrors) begin
            $display("test %0d %s: pass", number, name);
        end else begin
            testsFailed++;
            $display("test %0d %s: fail with %0d errors", number, name, errors - testErrors);
        end
        testErrors = errors;
    endtask

    initial begin
        logic [31:0] address;
        logic [31:0] data;
        logic [31:0] compare;
        logic [7:0]  word;
        clk         = 1'b0;
        reset       = 1'b1;
        hostReq     = '0;
        stimLfsr    = 32'd22;
        randomModel = `RANDOM_SEED;
        cycleCount  = 0;
        errors      = 0;
        checks      = 0;
        testsFailed = 0;
        testErrors  = 0;
        stalls      = 0;
        expValid    = 1'b0;
        expExact    = 1'b1;
        expData     = 32'h0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        // ram writes, then reads mostly back to back
        for (int i = 0; i < 64; i++) begin
            word = nextBits(8);
            data = nextBits(32);
            ramModel[word] = data;
            ramUsed.push_back(word);
            access(`RAM_BASE + {22'h0, word, 2'b00}, 1'b1, data, 1'b1);
        end
        for (int i = 0; i < 64; i++) begin
            word = ramUsed[i];
            access(`RAM_BASE + {22'h0, word, 2'b00}, 1'b0, ramModel[word], 1'b1);
            checkStalls(0);
            if (nextBits(2) == 32'h0) begin
                idle(1);
            end
        end
        idle(1);
        endTest(1, "scratch RAM");

        // unmapped, low bits alias a used ram word
        for (int i = 0; i < 16; i++) begin
            word    = ramUsed[nextBits(6)];
            address = 32'h80000000 | (nextBits(21) << 10) | {22'h0, word, 2'b00};
            access(address, 1'b1, nextBits(32), 1'b1);
            access(address, 1'b0, 32'h0, 1'b1);
            access(`RAM_BASE + {22'h0, word, 2'b00}, 1'b0, ramModel[word], 1'b1);
        end
        idle(1);
        endTest(2, "unmapped addresses");

        // sequence and stall span
        for (int i = 0; i < 8; i++) begin
            access(`RANDOM_BASE, 1'b0, randomModel, 1'b1);
            checkStalls((i == 0) ? 0 : `RANDOM_STEPS);
            randomModel = stirred(randomModel);
        end
        // reseed waits out the restir
        data = nextBits(32) | 32'h1;
        access(`RANDOM_BASE, 1'b1, data, 1'b1);
        checkStalls(`RANDOM_STEPS);
        randomModel = data;
        for (int i = 0; i < 3; i++) begin
            access(`RANDOM_BASE, 1'b0, randomModel, 1'b1);
            checkStalls((i == 0) ? 0 : `RANDOM_STEPS);
            randomModel = stirred(randomModel);
        end
        // zero seed dropped
        idle(`RANDOM_STEPS);
        access(`RANDOM_BASE, 1'b1, 32'h0, 1'b1);
        checkStalls(0);
        access(`RANDOM_BASE, 1'b0, randomModel, 1'b1);
        randomModel = stirred(randomModel);
        idle(1);
        endTest(3, "random source");

        // one-shot match
        compare = 32'd20 + nextBits(5);
        timerStart(compare, 32'h1);
        access(timerAddr(socBusPkg::regStatus), 1'b0, 32'h0, 1'b1);
        idleIrq(1'b0);
        idle(compare + 4);
        access(timerAddr(socBusPkg::regStatus), 1'b0, 32'h1, 1'b1);
        idleIrq(1'b1);
        access(timerAddr(socBusPkg::regCompare), 1'b0, compare, 1'b1);
        access(timerAddr(socBusPkg::regControl), 1'b0, 32'h1, 1'b1);
        // clear, count is already past compare
        access(timerAddr(socBusPkg::regStatus), 1'b1, 32'h1, 1'b1);
        idleIrq(1'b0);
        access(timerAddr(socBusPkg::regStatus), 1'b0, 32'h0, 1'b1);
        idle(1);
        endTest(4, "timer match");

        // auto-reload keeps count at or below compare
        compare = 32'd8 + nextBits(4);
        timerStart(compare, 32'h3);
        for (int i = 0; i < 24; i++) begin
            access(timerAddr(socBusPkg::regCount), 1'b0, compare, 1'b0);
            if (nextBits(1) == 32'h1) begin
                idle(1);
            end
        end
        access(timerAddr(socBusPkg::regStatus), 1'b0, 32'h1, 1'b1);
        access(timerAddr(socBusPkg::regStatus), 1'b1, 32'h1, 1'b1);
        // one period later the flag is back
        idle(2 * compare + 4);
        access(timerAddr(socBusPkg::regStatus), 1'b0, 32'h1, 1'b1);
        idleIrq(1'b1);
        endTest(5, "timer auto-reload");

        // reset with the timer running, irq high and the random source restirring
        access(`RANDOM_BASE, 1'b0, randomModel, 1'b1);
        // address stays on the random source so waitRequest shows its busy
        hostReq.read <= 1'b0;
        sample();
        checks++;
        if (waitRequest !== 1'b1) begin
            failValue("waitRequest", {31'h0, waitRequest}, 32'h1);
        end
        @(posedge clk);
        reset <= 1'b1;
        repeat (3) begin
            sample();
            @(posedge clk);
        end
        @(negedge clk);
        checks++;
        if ((waitRequest !== 1'b0) || (hostResp.valid !== 1'b0) || (timerIrq !== 1'b0)) begin
            errors++;
            $display("outputs still active while reset is held");
        end
        @(posedge clk);
        reset <= 1'b0;
        randomModel = `RANDOM_SEED;
        access(timerAddr(socBusPkg::regCount), 1'b0, 32'h0, 1'b1);
        access(`RANDOM_BASE, 1'b0, randomModel, 1'b1);
        randomModel = stirred(randomModel);
        idle(1);
        endTest(6, "reset");

        // failures caught by the bound checker
        if (dut0.interconnect0.assert0.failures != 0) begin
            $display("bound assertions failed %0d times", dut0.interconnect0.assert0.failures);
            errors += dut0.interconnect0.assert0.failures;
        end

        $display("tests 6, failed %0d, checks %0d, errors %0d", testsFailed, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/socBus_assert.sv ====
// bound handshake and decode checks, attached to every socInterconnect instance

`default_nettype none

module socBusAssert (
    input logic                   clk,
    input logic                   reset,
    input socBusPkg::busRequest   hostReq,
    input logic                   waitRequest,
    input socBusPkg::busResponse  hostResp,
    input socBusPkg::slaveRequest ramReq,
    input socBusPkg::slaveRequest randomReq,
    input socBusPkg::slaveRequest timerReq,
    input socBusPkg::slaveSel     sel
);

    logic       readAccepted;
    logic [5:0] strobes;
    int         failures = 0;

    assign readAccepted = hostReq.read && !waitRequest;
    assign strobes      = {ramReq.read, ramReq.write, randomReq.read,
                           randomReq.write, timerReq.read, timerReq.write};

    // every accepted read answered one cycle later
    readValidFollows: assert property (@(posedge clk) disable iff (reset)
        readAccepted |=> hostResp.valid)
        else begin
            failures++;
            $error("readValid missing one cycle after an accepted read");
        end

    // and nothing without one
    noSpuriousValid: assert property (@(posedge clk) disable iff (reset)
        !readAccepted |=> !hostResp.valid)
        else begin
            failures++;
            $error("readValid with no read accepted the cycle before");
        end

    // at most one slave strobe
    strobesOneHot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(strobes))
        else begin
            failures++;
            $error("more than one slave strobe high");
        end

    // stalled request reaches no slave
    stallBlocksStrobes: assert property (@(posedge clk) disable iff (reset)
        waitRequest |-> (strobes == 6'b0))
        else begin
            failures++;
            $error("slave strobe high while waitRequest stalls the master");
        end

    // unmapped read answered by the interconnect with zero data
    unmappedReadsZero: assert property (@(posedge clk) disable iff (reset)
        (readAccepted && (sel == socBusPkg::selNone)) |=>
            (hostResp.valid && (hostResp.data == 32'h0)))
        else begin
            failures++;
            $error("unmapped read not answered with valid and zero data");
        end

endmodule

bind socInterconnect socBusAssert assert0 (
    .clk         (clk),
    .reset       (reset),
    .hostReq     (hostReq),
    .waitRequest (waitRequest),
    .hostResp    (hostResp),
    .ramReq      (ramReq),
    .randomReq   (randomReq),
    .timerReq    (timerReq),
    .sel         (sel)
);

`default_nettype wire
